//--- verif/uart_cases.txt
# name, mode (loop, stall or badstop), listed byte count, LFSR byte count,
# then the listed bytes in hex; badstop sends its first byte with a low stop bit
single loop 1 0 a5
edges loop 4 0 00 ff 55 aa
walking_one loop 8 0 01 02 04 08 10 20 40 80
lfsr_bytes loop 0 8
burst loop 6 6 de ad be ef 12 34
rx_full stall 12 0 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb
bad_stop badstop 2 0 3c 96
bad_stop_lfsr badstop 1 2 f0
after_bad loop 3 0 7e 81 00

//--- verilog.f
logic/uart_pkg.sv
logic/baud_gen.sv
logic/fifo_ctrl.sv
logic/fifo_reg_file.sv
logic/fifo_buffer.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_top.sv
verif/tb_clock.sv
verif/uart_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir
if ! verilator --binary --timing --assert -Wno-fatal \
        -f verilog.f --top-module uart_tb -Mdir obj_dir -o uart_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/uart_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

//--- verif/uart_tb.sv
`timescale 1ns/100ps

// Loopback testbench for uart_top
module uart_tb;

    localparam int addr_width     = 3;
    localparam int dvsr           = 3;
    localparam int fifo_depth     = 2**addr_width;
    // One bit in clocks, ten bits per 8N1 frame
    localparam int bit_clocks     = uart_pkg::oversample_ticks * (dvsr + 1);
    localparam int frame_clocks   = 10 * bit_clocks;
    localparam int timeout_cycles = 20 * frame_clocks;

    typedef logic [8*24-1:0] text_t;

    logic            clk;
    logic            reset;
    uart_pkg::byte_t in_data;
    logic            in_valid;
    logic            in_ready;
    uart_pkg::byte_t out_data;
    logic            out_valid;
    logic            out_ready;
    logic            tx;
    logic            frame_error;
    logic            inject;
    logic            rx_drive;
    logic            line;
    logic            line_prev;

    // Monitor results
    uart_pkg::byte_t got[$];
    int              fe_count;
    int              frames_done;
    int              frame_left;

    // Run bookkeeping
    logic [7:0]      lfsr;
    string           test_name;
    int              errors;
    int              tests_run;
    int              tests_failed;
    int              first_stall;
    int              sent_count;

    tb_clock #(.reset_cycles(16)) clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    uart_top #(.addr_width(addr_width), .dvsr(dvsr)) UUT (
        .clk         (clk),
        .reset       (reset),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .rx          (line),
        .tx          (tx),
        .frame_error (frame_error)
    );

    // Loopback unless a test drives the line
    assign line = inject ? rx_drive : tx;

    //////////////////////////////////////////////////
    // Monitors
    //////////////////////////////////////////////////

    // Output handshakes and frame error pulses
    always @(posedge clk)
    begin
        if (reset)
        begin
            fe_count <= 0;
        end
        else
        begin
            if (out_valid && out_ready)
            begin
                got.push_back(out_data);
            end
            if (frame_error)
            begin
                fe_count <= fe_count + 1;
            end
        end
    end

    // Frame counter on the serial line
    // Done a quarter bit before the stop bit ends
    // Past the receiver's stop sample, ahead of the next start bit
    always @(posedge clk)
    begin
        line_prev <= line;
        if (reset)
        begin
            frames_done <= 0;
            frame_left  <= 0;
        end
        else if (frame_left > 0)
        begin
            frame_left <= frame_left - 1;
            if (frame_left == 1)
            begin
                frames_done <= frames_done + 1;
            end
        end
        else if (line_prev && !line)
        begin
            frame_left <= frame_clocks - bit_clocks / 4;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // x^8 + x^6 + x^5 + x^4 + 1, shifting toward bit 0
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[4], s[7:1]};
    endfunction

    // One LFSR step per bit
    task automatic take_random_byte(output uart_pkg::byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++)
        begin
            b    = {lfsr[0], b[7:1]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_equal(input string what, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("error %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s gave up waiting for %s", test_name, what);
        errors++;
    endtask

    // Offer one byte, return after the accepting edge
    task automatic send_byte(input uart_pkg::byte_t b, output bit ok);
        int waited;
        waited   = 0;
        in_data  <= b;
        in_valid <= 1'b1;
        @(posedge clk);
        while (!in_ready && waited < timeout_cycles)
        begin
            // Where the transmit FIFO first pushed back
            if (first_stall < 0)
            begin
                first_stall = sent_count;
            end
            @(posedge clk);
            waited++;
        end
        ok = in_ready;
        if (ok)
        begin
            sent_count++;
        end
        else
        begin
            report_timeout("in_ready");
        end
    endtask

    task automatic wait_received(input int n, output bit ok);
        int waited;
        waited = 0;
        while (got.size() < n && waited < timeout_cycles)
        begin
            @(posedge clk);
            waited++;
        end
        ok = (got.size() >= n);
        if (!ok)
        begin
            report_timeout($sformatf("%0d bytes on the output", n));
        end
    endtask

    task automatic wait_frames(input int n, output bit ok);
        int waited;
        waited = 0;
        while (frames_done < n && waited < timeout_cycles)
        begin
            @(posedge clk);
            waited++;
        end
        ok = (frames_done >= n);
        if (!ok)
        begin
            report_timeout("the serial frames to finish");
        end
    endtask

    // Start bit, data LSB first, chosen stop level, then idle high
    task automatic drive_frame(input uart_pkg::byte_t b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            rx_drive <= bits[i];
            repeat (bit_clocks) @(posedge clk);
        end
        rx_drive <= 1'b1;
        repeat (2 * bit_clocks) @(posedge clk);
    endtask

    //////////////////////////////////////////////////
    // One case from the file
    //////////////////////////////////////////////////

    task automatic run_case(input text_t mode, input uart_pkg::byte_t bytes[$]);
        uart_pkg::byte_t expected[$];
        int              errors_before;
        int              fe_before;
        int              frames_before;
        int              waited;
        bit              is_stall;
        bit              is_bad;
        bit              ok;
        errors_before = errors;
        fe_before     = fe_count;
        frames_before = frames_done;
        is_stall      = (mode == text_t'("stall"));
        is_bad        = (mode == text_t'("badstop"));
        first_stall   = -1;
        sent_count    = 0;
        ok            = 1'b1;
        got.delete();
        out_ready <= !is_stall;
        if (is_bad)
        begin
            inject <= 1'b1;
            // Low stop bit, must vanish with one error pulse
            drive_frame(bytes[0], 1'b0);
            wait_frames(frames_before + 1, ok);
            check_equal("frame errors", 1, fe_count - fe_before);
            check_equal("bytes after bad frame", 0, got.size());
            check_equal("out_valid after bad frame", 0, out_valid);
            for (int i = 1; i < bytes.size(); i++)
            begin
                drive_frame(bytes[i], 1'b1);
                expected.push_back(bytes[i]);
            end
        end
        else
        begin
            for (int i = 0; i < bytes.size() && ok; i++)
            begin
                send_byte(bytes[i], ok);
            end
            in_valid <= 1'b0;
            // Eight in the FIFO plus one already in the serializer
            if (bytes.size() > fifo_depth + 1)
            begin
                check_equal("bytes taken before in_ready fell", fifo_depth + 1, first_stall);
            end
            for (int i = 0; i < bytes.size(); i++)
            begin
                if (!is_stall || i < fifo_depth)
                begin
                    expected.push_back(bytes[i]);
                end
            end
            if (is_stall && ok)
            begin
                wait_frames(frames_before + bytes.size(), ok);
                out_ready <= 1'b1;
            end
        end
        if (ok)
        begin
            wait_received(expected.size(), ok);
        end
        // Receive FIFO drained, valid must drop
        waited = 0;
        while (ok && out_valid && waited < timeout_cycles)
        begin
            @(posedge clk);
            waited++;
        end
        if (out_valid)
        begin
            report_timeout("out_valid to fall");
        end
        if (!is_bad)
        begin
            check_equal("frame errors", 0, fe_count - fe_before);
        end
        check_equal("received count", expected.size(), got.size());
        for (int i = 0; i < expected.size() && i < got.size(); i++)
        begin
            check_equal($sformatf("byte %0d", i), expected[i], got[i]);
        end
        inject <= 1'b0;
        // Let the transmitter finish its stop bit
        repeat (bit_clocks) @(posedge clk);
        tests_run++;
        if (errors == errors_before)
        begin
            $display("%s: ok, %0d bytes", test_name, bytes.size());
        end
        else
        begin
            tests_failed++;
            $display("%s: failed", test_name);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        int              fd;
        int              r;
        int              n_list;
        int              n_rand;
        int              waited;
        text_t           name_raw;
        text_t           mode_raw;
        logic [8*128-1:0] rest;
        uart_pkg::byte_t b;
        uart_pkg::byte_t bytes[$];
        in_data      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        inject       = 1'b0;
        rx_drive     = 1'b1;
        lfsr         = 8'd179;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "after_reset";

        waited = 0;
        @(posedge clk);
        while (reset && waited < timeout_cycles)
        begin
            @(posedge clk);
            waited++;
        end
        if (reset)
        begin
            report_timeout("reset to be released");
        end
        // Idle state straight out of reset
        check_equal("in_ready", 1, in_ready);
        check_equal("out_valid", 0, out_valid);
        check_equal("frame_error", 0, frame_error);
        check_equal("tx", 1, tx);
        tests_run++;
        $display("%s: %s", test_name, (errors == 0) ? "ok" : "failed");
        if (errors != 0)
        begin
            tests_failed++;
        end

        fd = $fopen("verif/uart_cases.txt", "r");
        if (fd == 0)
        begin
            $display("the cases file verif/uart_cases.txt could not be opened");
            errors++;
        end
        while (fd != 0 && $fscanf(fd, "%s", name_raw) == 1)
        begin
            // Comment line
            if (name_raw == text_t'("#"))
            begin
                r = $fgets(rest, fd);
                continue;
            end
            r = $fscanf(fd, "%s %d %d", mode_raw, n_list, n_rand);
            bytes.delete();
            for (int i = 0; i < n_list; i++)
            begin
                r = $fscanf(fd, "%h", b);
                bytes.push_back(b);
            end
            for (int i = 0; i < n_rand; i++)
            begin
                take_random_byte(b);
                bytes.push_back(b);
            end
            test_name = $sformatf("%0s", name_raw);
            run_case(mode_raw, bytes);
        end
        if (fd != 0)
        begin
            $fclose(fd);
        end
        if (tests_run < 2)
        begin
            $display("no test cases were read from the cases file");
            errors++;
        end

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/100ps

// Testbench clock and power-on reset
module tb_clock
#(
    parameter int reset_cycles = 16
)
(
    output logic clk,
    output logic reset
);
    // 8 ns period
    localparam real half_period = 4.0;

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Reset released on a rising edge
    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- logic/uart_top.sv
`timescale 1ns/100ps

// UART subsystem top
// Byte streams in and out, serial line on tx and rx
module uart_top
#(
    parameter int addr_width = 3,
    parameter int dvsr       = 3
)
(
    input  logic            clk,
    input  logic            reset,
    input  uart_pkg::byte_t in_data,
    input  logic            in_valid,
    output logic            in_ready,
    output uart_pkg::byte_t out_data,
    output logic            out_valid,
    input  logic            out_ready,
    input  logic            rx,
    output logic            tx,
    output logic            frame_error
);
    logic            tick;
    uart_pkg::byte_t tx_fifo_data;
    logic            tx_fifo_valid;
    logic            tx_fifo_ready;
    uart_pkg::byte_t rx_data;
    logic            rx_push;

    // Shared oversample tick
    baud_gen #(.dvsr(dvsr)) baud (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    //////////////////////////////////////////////////
    // Transmit path
    //////////////////////////////////////////////////

    fifo_buffer #(.addr_width(addr_width)) tx_fifo (
        .clk        (clk),
        .reset      (reset),
        .push_data  (in_data),
        .push_valid (in_valid),
        .push_ready (in_ready),
        .pop_data   (tx_fifo_data),
        .pop_valid  (tx_fifo_valid),
        .pop_ready  (tx_fifo_ready)
    );

    uart_tx transmitter (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .data  (tx_fifo_data),
        .valid (tx_fifo_valid),
        .ready (tx_fifo_ready),
        .tx    (tx)
    );

    //////////////////////////////////////////////////
    // Receive path
    //////////////////////////////////////////////////

    uart_rx receiver (
        .clk         (clk),
        .reset       (reset),
        .tick        (tick),
        .rx          (rx),
        .data        (rx_data),
        .push        (rx_push),
        .frame_error (frame_error)
    );

    // No back-pressure on the line, full FIFO drops the byte
    fifo_buffer #(.addr_width(addr_width)) rx_fifo (
        .clk        (clk),
        .reset      (reset),
        .push_data  (rx_data),
        .push_valid (rx_push),
        .push_ready (),
        .pop_data   (out_data),
        .pop_valid  (out_valid),
        .pop_ready  (out_ready)
    );

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/100ps

// 16x oversampling transmitter, 8N1
// Pulls bytes from the transmit FIFO
module uart_tx
(
    input  logic            clk,
    input  logic            reset,
    input  logic            tick,
    input  uart_pkg::byte_t data,
    input  logic            valid,
    output logic            ready,
    output logic            tx
);
    uart_pkg::serial_state_t state;
    uart_pkg::os_count_t     tick_cnt;
    logic [2:0]              bit_cnt;
    uart_pkg::byte_t         shift_reg;
    logic                    bit_done;

    // Take the head byte only while idle
    assign ready = (state == uart_pkg::idle) && valid;

    // Last tick of the current bit
    assign bit_done = tick && (tick_cnt == uart_pkg::os_count_t'(uart_pkg::oversample_ticks - 1));

    //////////////////////////////////////////////////
    // Frame FSM and line driver
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= uart_pkg::idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end
        else
        begin
            if (tick)
            begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                uart_pkg::idle:
                begin
                    tx <= 1'b1;
                    if (valid)
                    begin
                        state    <= uart_pkg::start;
                        tick_cnt <= '0;
                        tx       <= 1'b0;
                    end
                end
                uart_pkg::start:
                begin
                    if (bit_done)
                    begin
                        state   <= uart_pkg::data;
                        bit_cnt <= '0;
                        tx      <= shift_reg[0];
                    end
                end
                uart_pkg::data:
                begin
                    if (bit_done)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(uart_pkg::data_bits - 1))
                        begin
                            state <= uart_pkg::stop;
                            tx    <= 1'b1;
                        end
                        else
                        begin
                            tx <= shift_reg[1];
                        end
                    end
                end
                default:
                begin
                    // Stop bit held high for a full period
                    if (bit_done)
                    begin
                        state <= uart_pkg::idle;
                    end
                end
            endcase
        end
    end

    // Load on accept, shift LSB first
    always_ff @(posedge clk)
    begin
        if (ready)
        begin
            shift_reg <= data;
        end
        else if (state == uart_pkg::data && bit_done)
        begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/100ps

// 16x oversampling receiver, 8N1
// Samples each bit at its middle
module uart_rx
(
    input  logic            clk,
    input  logic            reset,
    input  logic            tick,
    input  logic            rx,
    output uart_pkg::byte_t data,
    output logic            push,
    output logic            frame_error
);
    uart_pkg::serial_state_t state;
    uart_pkg::os_count_t     tick_cnt;
    logic [2:0]              bit_cnt;
    uart_pkg::byte_t         shift_reg;
    logic                    rx_meta;
    logic                    rx_sync;
    logic                    rx_prev;
    logic                    half_bit;
    logic                    full_bit;
    logic                    stop_sample;

    //////////////////////////////////////////////////
    // Input synchronizer and edge history
    //////////////////////////////////////////////////

    // Line idles high
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Mid-bit and end-of-bit tick points
    assign half_bit = tick &&
        (tick_cnt == uart_pkg::os_count_t'(uart_pkg::oversample_ticks / 2 - 1));
    assign full_bit = tick &&
        (tick_cnt == uart_pkg::os_count_t'(uart_pkg::oversample_ticks - 1));

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= uart_pkg::idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            case (state)
                uart_pkg::idle:
                begin
                    // Falling edge starts the count
                    if (rx_prev && !rx_sync)
                    begin
                        state    <= uart_pkg::start;
                        tick_cnt <= '0;
                    end
                end
                uart_pkg::start:
                begin
                    if (half_bit)
                    begin
                        // Glitch shorter than half a bit goes back to idle
                        state    <= rx_sync ? uart_pkg::idle : uart_pkg::data;
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                    else if (tick)
                    begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::data:
                begin
                    if (full_bit)
                    begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(uart_pkg::data_bits - 1))
                        begin
                            state <= uart_pkg::stop;
                        end
                    end
                    else if (tick)
                    begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default:
                begin
                    // Stop bit, return to idle at its middle
                    if (full_bit)
                    begin
                        state    <= uart_pkg::idle;
                        tick_cnt <= '0;
                    end
                    else if (tick)
                    begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, shifts in from the top
    always_ff @(posedge clk)
    begin
        if (state == uart_pkg::data && full_bit)
        begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    // Stop bit decides push or error
    assign stop_sample = (state == uart_pkg::stop) && full_bit;
    assign push        = stop_sample && rx_sync;
    assign frame_error = stop_sample && !rx_sync;
    assign data        = shift_reg;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // A frame ends in exactly one outcome
    one_outcome: assert property (@(posedge clk) disable iff (reset)
        !(push && frame_error));

endmodule

//--- logic/fifo_buffer.sv
`timescale 1ns/100ps

// Fall-through FIFO with valid/ready on both sides
module fifo_buffer
#(
    parameter int addr_width = 3
)
(
    input  logic            clk,
    input  logic            reset,
    input  uart_pkg::byte_t push_data,
    input  logic            push_valid,
    output logic            push_ready,
    output uart_pkg::byte_t pop_data,
    output logic            pop_valid,
    input  logic            pop_ready
);
    logic                  full;
    logic                  empty;
    logic                  push_accept;
    logic [addr_width-1:0] w_addr;
    logic [addr_width-1:0] r_addr;

    // Write only lands when there is room
    assign push_accept = push_valid & ~full;

    fifo_ctrl #(.addr_width(addr_width)) ctrl (
        .clk    (clk),
        .reset  (reset),
        .wr     (push_accept),
        .rd     (pop_ready),
        .full   (full),
        .empty  (empty),
        .w_addr (w_addr),
        .r_addr (r_addr)
    );

    fifo_reg_file #(.addr_width(addr_width)) regs (
        .clk    (clk),
        .wr_en  (push_accept),
        .w_addr (w_addr),
        .r_addr (r_addr),
        .w_data (push_data),
        .r_data (pop_data)
    );

    // Flags map straight onto the handshakes
    assign push_ready = ~full;
    assign pop_valid  = ~empty;

endmodule

//--- logic/fifo_reg_file.sv
`timescale 1ns/100ps

// FIFO storage array
// Synchronous write, combinational read
module fifo_reg_file
#(
    parameter int addr_width = 3
)
(
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] w_addr,
    input  logic [addr_width-1:0] r_addr,
    input  uart_pkg::byte_t       w_data,
    output uart_pkg::byte_t       r_data
);
    // One entry per pointer value
    uart_pkg::byte_t mem [2**addr_width];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[w_addr] <= w_data;
        end
    end

    // Head entry visible without a read strobe
    assign r_data = mem[r_addr];

endmodule

//--- logic/fifo_ctrl.sv
`timescale 1ns/100ps

// Pointer and flag controller
// First word falls through, head is always at r_addr
module fifo_ctrl
#(
    parameter int addr_width = 3
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr,
    input  logic                  rd,
    output logic                  full,
    output logic                  empty,
    output logic [addr_width-1:0] w_addr,
    output logic [addr_width-1:0] r_addr
);
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] wr_ptr_next;
    logic [addr_width-1:0] wr_ptr_succ;
    logic [addr_width-1:0] rd_ptr;
    logic [addr_width-1:0] rd_ptr_next;
    logic [addr_width-1:0] rd_ptr_succ;
    logic                  full_next;
    logic                  empty_next;

    //////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end
        else
        begin
            wr_ptr <= wr_ptr_next;
            rd_ptr <= rd_ptr_next;
            full   <= full_next;
            empty  <= empty_next;
        end
    end

    // Pointers wrap naturally at 2**addr_width
    assign wr_ptr_succ = wr_ptr + 1'b1;
    assign rd_ptr_succ = rd_ptr + 1'b1;

    //////////////////////////////////////////////////
    // Next state on the request pair
    //////////////////////////////////////////////////

    always_comb
    begin
        // Hold by default
        wr_ptr_next = wr_ptr;
        rd_ptr_next = rd_ptr;
        full_next   = full;
        empty_next  = empty;
        case ({wr, rd})
            // Read only
            2'b01:
            begin
                if (!empty)
                begin
                    rd_ptr_next = rd_ptr_succ;
                    full_next   = 1'b0;
                    empty_next  = (rd_ptr_succ == wr_ptr);
                end
            end
            // Write only
            2'b10:
            begin
                if (!full)
                begin
                    wr_ptr_next = wr_ptr_succ;
                    empty_next  = 1'b0;
                    full_next   = (wr_ptr_succ == rd_ptr);
                end
            end
            // Both at once
            2'b11:
            begin
                if (empty)
                begin
                    // Nothing to read yet, so just the write
                    wr_ptr_next = wr_ptr_succ;
                    empty_next  = 1'b0;
                    full_next   = (wr_ptr_succ == rd_ptr);
                end
                else
                begin
                    // Occupancy unchanged, flags hold even when full
                    wr_ptr_next = wr_ptr_succ;
                    rd_ptr_next = rd_ptr_succ;
                end
            end
            default:
            begin
            end
        endcase
    end

    assign w_addr = wr_ptr;
    assign r_addr = rd_ptr;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Flags never claim full and empty together
    flags_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(full && empty));

    // Head stays put across any cycle that starts empty
    head_holds_when_empty: assert property (@(posedge clk) disable iff (reset)
        empty |=> $stable(rd_ptr));

endmodule

//--- logic/baud_gen.sv
`timescale 1ns/100ps

// Oversample tick generator
// Divides clk by dvsr+1
module baud_gen
#(
    parameter int dvsr = 3
)
(
    input  logic clk,
    input  logic reset,
    output logic tick
);
    // Wide enough to hold dvsr
    localparam int cnt_width = (dvsr > 0) ? $clog2(dvsr + 1) : 1;

    logic [cnt_width-1:0] count;

    // Free-running count from 0 to dvsr
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (count == cnt_width'(dvsr))
        begin
            count <= '0;
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    // One-clock pulse at the wrap
    assign tick = (count == cnt_width'(dvsr));

endmodule

//--- logic/uart_pkg.sv
// Shared types and constants for the UART subsystem
package uart_pkg;

    //////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////

    // One serial data byte
    typedef logic [7:0] byte_t;

    // Oversample tick counter within one bit
    typedef logic [3:0] os_count_t;

    //////////////////////////////////////////////////
    // Frame constants
    //////////////////////////////////////////////////

    // Ticks per bit period
    localparam int oversample_ticks = 16;

    // Data bits per frame, no parity
    localparam int data_bits = 8;

    // Frame phase of both serial engines
    typedef enum logic [1:0]
    {
        idle,
        start,
        data,
        stop
    } serial_state_t;

endpackage
